/* pool_pkg.sv */
package pool_pkg;

	// activation, parameter word and address widths
	localparam int DATA_W  = 8;
	localparam int PARAM_W = 16;
	localparam int ADDR_W  = 16;

	// kernel code for 2x2 windows, every other code gives 8x8
	localparam logic [PARAM_W-1:0] KERNEL_SMALL = 16'd2;

	// most negative activation
	localparam logic signed [DATA_W-1:0] MAX_INIT = {1'b1, {(DATA_W-1){1'b0}}};

	typedef logic [ADDR_W-1:0] addr_t;

	// layer configuration as read from the parameter memory
	typedef struct packed {
		logic [5:0]         num_row;
		logic [7:0]         num_channel;
		logic [PARAM_W-1:0] kernel_code;
	} pool_cfg_t;

	// read port request, data returns one cycle later
	typedef struct packed {
		logic  cs;
		addr_t addr;
	} rd_req_t;

	// write port request, taken at the clock edge
	typedef struct packed {
		logic              cs;
		logic              we;
		addr_t             addr;
		logic [DATA_W-1:0] data;
	} wr_req_t;

endpackage

/* pool_ctrl.sv */
`timescale 1ns/1ps

module pool_ctrl (
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  logic       last_elem,
	input  logic       last_win,
	output logic       cfg_load,
	output logic       param_cs,
	output logic [1:0] param_addr,
	output logic       elem_step,
	output logic       win_first,
	output logic       acc_en,
	output logic       win_write,
	output logic       done
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_PARAM,
		S_READ,
		S_DRAIN,
		S_WRITE,
		S_DONE
	} state_t;

	state_t     state_q;
	state_t     state_d;
	logic [1:0] param_cnt;
	logic       first_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q <= S_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				if (start) begin
					state_d = S_PARAM;
				end
			end
			// three reads plus one cycle for the last word to return
			S_PARAM: begin
				if (param_cnt == 2'd3) begin
					state_d = S_READ;
				end
			end
			S_READ: begin
				if (last_elem) begin
					state_d = S_DRAIN;
				end
			end
			S_DRAIN: begin
				state_d = S_WRITE;
			end
			S_WRITE: begin
				if (last_win) begin
					state_d = S_DONE;
				end else begin
					state_d = S_READ;
				end
			end
			default: begin
				state_d = S_IDLE;
			end
		endcase
	end

	// parameter word counter, idles at zero
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			param_cnt <= 2'd0;
		end else if (state_q == S_PARAM) begin
			param_cnt <= param_cnt + 2'd1;
		end else begin
			param_cnt <= 2'd0;
		end
	end

	// high during the first read cycle of each window
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			first_q <= 1'b0;
		end else begin
			first_q <= (state_d == S_READ) && (state_q != S_READ);
		end
	end

	// strobes for the datum arriving one cycle after its read
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc_en    <= 1'b0;
			win_first <= 1'b0;
		end else begin
			acc_en    <= elem_step;
			win_first <= elem_step && first_q;
		end
	end

	assign param_cs   = (state_q == S_PARAM) && (param_cnt != 2'd3);
	assign param_addr = param_cnt;
	assign cfg_load   = param_cs;
	assign elem_step  = (state_q == S_READ);
	assign win_write  = (state_q == S_WRITE);
	assign done       = (state_q == S_DONE);

endmodule

/* pool_cfg_regs.sv */
`timescale 1ns/1ps

module pool_cfg_regs import pool_pkg::*; #(
	parameter int ADDR_W = pool_pkg::ADDR_W
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               cfg_load,
	input  logic [1:0]         param_addr,
	input  logic [PARAM_W-1:0] param_rdata,
	output pool_cfg_t          cfg,
	output logic [9:0]         win_len,
	output logic [3:0]         k_side,
	output logic [ADDR_W-1:0]  out_count
);

	logic       load_q;
	logic [1:0] addr_q;
	logic       small_k;
	logic [5:0] win_per_row;

	// word for address n shows up the cycle after the read
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			load_q <= 1'b0;
			addr_q <= 2'd0;
		end else begin
			load_q <= cfg_load;
			addr_q <= param_addr;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cfg <= '0;
		end else if (load_q) begin
			case (addr_q)
				2'd0: cfg.num_row     <= param_rdata[5:0];
				2'd1: cfg.num_channel <= param_rdata[7:0];
				2'd2: cfg.kernel_code <= param_rdata;
				default: cfg <= cfg;
			endcase
		end
	end

	assign small_k     = (cfg.kernel_code == KERNEL_SMALL);
	assign k_side      = small_k ? 4'd2 : 4'd8;
	assign win_per_row = small_k ? (cfg.num_row >> 1) : (cfg.num_row >> 3);

	// windows per layer is channels times (side/k) squared
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			win_len   <= 10'd0;
			out_count <= '0;
		end else begin
			win_len   <= 10'(k_side) * 10'(k_side);
			out_count <= ADDR_W'(win_per_row) * ADDR_W'(win_per_row) * ADDR_W'(cfg.num_channel);
		end
	end

endmodule

/* pool_addr_gen.sv */
`timescale 1ns/1ps

module pool_addr_gen import pool_pkg::*; #(
	parameter int ADDR_W = pool_pkg::ADDR_W
) (
	input  logic              clk,
	input  logic              rst,
	input  pool_cfg_t         cfg,
	input  logic [3:0]        k_side,
	input  logic [9:0]        win_len,
	input  logic [ADDR_W-1:0] out_count,
	input  logic              elem_step,
	input  logic              win_write,
	input  logic              start,
	output logic [ADDR_W-1:0] in_addr,
	output logic [ADDR_W-1:0] out_addr,
	output logic              last_elem,
	output logic              last_win
);

	logic [9:0]        elem_cnt;
	logic [3:0]        col_off;
	logic [3:0]        row_off;
	logic [5:0]        win_col;
	logic [5:0]        win_col_nxt;
	logic [ADDR_W-1:0] row_base;
	logic [ADDR_W-1:0] row_step;
	logic [ADDR_W-1:0] out_idx;

	assign last_elem   = (elem_cnt == win_len - 10'd1);
	assign last_win    = (out_idx == out_count - ADDR_W'(1));
	assign win_col_nxt = win_col + 6'(k_side);

	// one row of windows spans k full feature-map rows
	assign row_step = ADDR_W'(cfg.num_row) * ADDR_W'(k_side);

	// origin plus row offset times side plus column offset
	assign in_addr = row_base + ADDR_W'(win_col)
		+ ADDR_W'(row_off) * ADDR_W'(cfg.num_row) + ADDR_W'(col_off);
	assign out_addr = out_idx;

	// element walk inside the current window
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			elem_cnt <= 10'd0;
			col_off  <= 4'd0;
			row_off  <= 4'd0;
		end else if (start || (elem_step && last_elem)) begin
			elem_cnt <= 10'd0;
			col_off  <= 4'd0;
			row_off  <= 4'd0;
		end else if (elem_step) begin
			elem_cnt <= elem_cnt + 10'd1;
			if (col_off == k_side - 4'd1) begin
				col_off <= 4'd0;
				row_off <= row_off + 4'd1;
			end else begin
				col_off <= col_off + 4'd1;
			end
		end
	end

	// window origin and output index, channels are contiguous so
	// stepping past the last window row lands on the next channel
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			win_col  <= 6'd0;
			row_base <= '0;
			out_idx  <= '0;
		end else if (start) begin
			win_col  <= 6'd0;
			row_base <= '0;
			out_idx  <= '0;
		end else if (win_write) begin
			out_idx <= out_idx + ADDR_W'(1);
			if (win_col_nxt == cfg.num_row) begin
				win_col  <= 6'd0;
				row_base <= row_base + row_step;
			end else begin
				win_col <= win_col_nxt;
			end
		end
	end

endmodule

/* pool_max_unit.sv */
`timescale 1ns/1ps

module pool_max_unit import pool_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              acc_en,
	input  logic              win_first_d,
	input  logic [DATA_W-1:0] in_rdata,
	output logic [DATA_W-1:0] max_val
);

	logic signed [DATA_W-1:0] max_q;
	logic signed [DATA_W-1:0] sample;

	// activations are two's complement
	assign sample = $signed(in_rdata);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			max_q <= MAX_INIT;
		end else if (acc_en) begin
			// first datum restarts the window
			if (win_first_d || (sample > max_q)) begin
				max_q <= sample;
			end
		end
	end

	assign max_val = max_q;

endmodule

/* pool_top.sv */
`timescale 1ns/1ps

module pool_top import pool_pkg::*; #(
	parameter int ADDR_W = pool_pkg::ADDR_W
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	output logic               done,
	output rd_req_t            param_req,
	input  logic [PARAM_W-1:0] param_rdata,
	output rd_req_t            in_req,
	input  logic [DATA_W-1:0]  in_rdata,
	output wr_req_t            out_req
);

	logic              cfg_load;
	logic              param_cs;
	logic [1:0]        param_addr;
	logic              elem_step;
	logic              win_first;
	logic              acc_en;
	logic              win_write;
	logic              last_elem;
	logic              last_win;
	pool_cfg_t         cfg;
	logic [9:0]        win_len;
	logic [3:0]        k_side;
	logic [ADDR_W-1:0] out_count;
	logic [ADDR_W-1:0] in_addr;
	logic [ADDR_W-1:0] out_addr;
	logic [DATA_W-1:0] max_val;

	pool_ctrl ctrl_i (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.last_elem  (last_elem),
		.last_win   (last_win),
		.cfg_load   (cfg_load),
		.param_cs   (param_cs),
		.param_addr (param_addr),
		.elem_step  (elem_step),
		.win_first  (win_first),
		.acc_en     (acc_en),
		.win_write  (win_write),
		.done       (done)
	);

	pool_cfg_regs #(
		.ADDR_W (ADDR_W)
	) cfg_i (
		.clk         (clk),
		.rst         (rst),
		.cfg_load    (cfg_load),
		.param_addr  (param_addr),
		.param_rdata (param_rdata),
		.cfg         (cfg),
		.win_len     (win_len),
		.k_side      (k_side),
		.out_count   (out_count)
	);

	// counters restart while the parameters are being loaded
	pool_addr_gen #(
		.ADDR_W (ADDR_W)
	) addr_i (
		.clk       (clk),
		.rst       (rst),
		.cfg       (cfg),
		.k_side    (k_side),
		.win_len   (win_len),
		.out_count (out_count),
		.elem_step (elem_step),
		.win_write (win_write),
		.start     (cfg_load),
		.in_addr   (in_addr),
		.out_addr  (out_addr),
		.last_elem (last_elem),
		.last_win  (last_win)
	);

	pool_max_unit max_i (
		.clk         (clk),
		.rst         (rst),
		.acc_en      (acc_en),
		.win_first_d (win_first),
		.in_rdata    (in_rdata),
		.max_val     (max_val)
	);

	assign param_req.cs   = param_cs;
	assign param_req.addr = addr_t'(param_addr);
	assign in_req.cs      = elem_step;
	assign in_req.addr    = addr_t'(in_addr);
	assign out_req.cs     = win_write;
	assign out_req.we     = win_write;
	assign out_req.addr   = addr_t'(out_addr);
	assign out_req.data   = max_val;

endmodule

/* tb_pool.sv */
`timescale 1ns/1ps

module tb_pool import pool_pkg::*; ();

	logic               clk = 1'b0;
	logic               rst;
	logic               start;
	logic               done;
	rd_req_t            param_req;
	rd_req_t            in_req;
	wr_req_t            out_req;
	logic [PARAM_W-1:0] param_rdata = '0;
	logic [DATA_W-1:0]  in_rdata = '0;

	logic [PARAM_W-1:0] param_mem [0:3];
	logic [DATA_W-1:0]  in_mem [0:1023];
	logic               param_pend_v = 1'b0;
	logic [1:0]         param_pend_a = '0;
	logic               in_pend_v = 1'b0;
	logic [9:0]         in_pend_a = '0;
	int                 wr_addr_q [$];
	logic [DATA_W-1:0]  wr_data_q [$];
	logic [31:0]        lfsr_state = 32'hfea1;
	int                 cycle_count = 0;
	int                 test_errs;
	int                 pass_count = 0;
	int                 fail_count = 0;

	// formula length of one layer run from start edge to done
	function automatic int layer_cycles(int side, int ch, int k);
		return 4 + ch * (side / k) * (side / k) * (k * k + 2) + 1;
	endfunction

	localparam int TIMEOUT_CYCLES = 10 + 20 + layer_cycles(8, 1, 2) + layer_cycles(4, 4, 2)
		+ 2 * layer_cycles(16, 2, 8) + layer_cycles(12, 1, 2) + 200;

	pool_top dut_i (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.done        (done),
		.param_req   (param_req),
		.param_rdata (param_rdata),
		.in_req      (in_req),
		.in_rdata    (in_rdata),
		.out_req     (out_req)
	);

	always #2 clk = ~clk;

	// memory models answer in the cycle after the request
	always @(negedge clk) begin
		param_rdata  <= param_pend_v ? param_mem[param_pend_a] : '0;
		in_rdata     <= in_pend_v ? in_mem[in_pend_a] : '0;
		param_pend_v <= param_req.cs;
		param_pend_a <= param_req.addr[1:0];
		in_pend_v    <= in_req.cs;
		in_pend_a    <= in_req.addr[9:0];
		if (out_req.cs && out_req.we) begin
			wr_addr_q.push_back(int'(out_req.addr));
			wr_data_q.push_back(out_req.data);
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	// one LFSR step per bit, upper bits left at zero
	function automatic logic [DATA_W-1:0] rand_bits(int n);
		logic [DATA_W-1:0] b;
		b = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			b[i] = lfsr_state[0];
		end
		return b;
	endfunction

	// signed maximum over one window of the input image
	function automatic logic signed [DATA_W-1:0] window_max(int side, int k, int ch,
		int wr, int wc);
		logic signed [DATA_W-1:0] m;
		logic signed [DATA_W-1:0] v;
		int base;
		base = ch * side * side + wr * k * side + wc * k;
		m = $signed(in_mem[base]);
		for (int r = 0; r < k; r++) begin
			for (int c = 0; c < k; c++) begin
				v = $signed(in_mem[base + r * side + c]);
				if (v > m) begin
					m = v;
				end
			end
		end
		return m;
	endfunction

	task automatic fill_window(int side, int k, int ch, int wr, int wc,
		logic [DATA_W-1:0] value);
		int base;
		base = ch * side * side + wr * k * side + wc * k;
		for (int r = 0; r < k; r++) begin
			for (int c = 0; c < k; c++) begin
				in_mem[base + r * side + c] = value;
			end
		end
	endtask

	task automatic finish_test(string name);
		if (test_errs == 0) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: failed with %0d errors", name, test_errs);
		end
	endtask

	// runs one full layer and checks it against the reference
	task automatic run_layer(string name, int side, int ch, int kcode);
		int k;
		int per_row;
		int nwin;
		int cycles;
		int idx;
		logic signed [DATA_W-1:0] exp;
		k = (kcode == 2) ? 2 : 8;
		per_row = side / k;
		nwin = ch * per_row * per_row;
		param_mem[0] = PARAM_W'(side);
		param_mem[1] = PARAM_W'(ch);
		param_mem[2] = PARAM_W'(kcode);
		param_mem[3] = '0;
		wr_addr_q.delete();
		wr_data_q.delete();
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		cycles = 1;
		while (!done) begin
			@(negedge clk);
			cycles++;
		end
		if (cycles != layer_cycles(side, ch, k)) begin
			$display("[ERROR] %s: cycles expected %0d got %0d", name,
				layer_cycles(side, ch, k), cycles);
			test_errs++;
		end
		@(negedge clk);
		if (done) begin
			$display("[ERROR] %s: done width expected 1 got more than 1", name);
			test_errs++;
		end
		if (wr_addr_q.size() != nwin) begin
			$display("[ERROR] %s: write count expected %0d got %0d", name, nwin,
				wr_addr_q.size());
			test_errs++;
		end
		for (int c = 0; c < ch; c++) begin
			for (int wr = 0; wr < per_row; wr++) begin
				for (int wc = 0; wc < per_row; wc++) begin
					idx = c * per_row * per_row + wr * per_row + wc;
					exp = window_max(side, k, c, wr, wc);
					if (idx < wr_addr_q.size()) begin
						if (wr_addr_q[idx] != idx) begin
							$display("[ERROR] %s: write %0d address expected %0d got %0d",
								name, idx, idx, wr_addr_q[idx]);
							test_errs++;
						end
						if (wr_data_q[idx] != exp) begin
							$display("[ERROR] %s: window %0d max expected %0d got %0d",
								name, idx, exp, $signed(wr_data_q[idx]));
							test_errs++;
						end
					end
				end
			end
		end
	endtask

	task automatic check_idle_outputs();
		test_errs = 0;
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			if (param_req.cs || in_req.cs || out_req.cs || out_req.we || done) begin
				$display("idle: a select, write enable or done went high before start, cycle %0d",
					i);
				test_errs++;
			end
		end
		finish_test("idle_outputs");
	endtask

	task automatic random_single_channel();
		test_errs = 0;
		for (int a = 0; a < 1024; a++) begin
			in_mem[a] = rand_bits(DATA_W);
		end
		run_layer("small_random", 8, 1, 2);
		finish_test("small_random");
	endtask

	task automatic negative_multi_channel();
		test_errs = 0;
		// sign bit forced on everywhere
		for (int a = 0; a < 1024; a++) begin
			in_mem[a] = 8'h80 | rand_bits(DATA_W - 1);
		end
		fill_window(4, 2, 1, 0, 0, 8'h80);
		fill_window(4, 2, 2, 1, 1, 8'hff);
		fill_window(4, 2, 3, 0, 1, 8'hc0);
		run_layer("negative_channels", 4, 4, 2);
		finish_test("negative_channels");
	endtask

	task automatic large_kernel_layer(string name, int kcode);
		test_errs = 0;
		for (int a = 0; a < 1024; a++) begin
			in_mem[a] = rand_bits(DATA_W);
		end
		run_layer(name, 16, 2, kcode);
		finish_test(name);
	endtask

	task automatic second_layer_restart();
		test_errs = 0;
		for (int a = 0; a < 1024; a++) begin
			in_mem[a] = rand_bits(DATA_W);
		end
		run_layer("restart_layer", 12, 1, 2);
		finish_test("restart_layer");
	endtask

	initial begin
		rst   = 1'b0;
		start = 1'b0;
		repeat (10) @(negedge clk);
		rst = 1'b1;
		check_idle_outputs();
		random_single_channel();
		negative_multi_channel();
		large_kernel_layer("large_kernel_8", 8);
		large_kernel_layer("large_kernel_5", 5);
		second_layer_restart();
		$display("tests passed: %0d  tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* sources.f */
pool_pkg.sv
pool_ctrl.sv
pool_cfg_regs.sv
pool_addr_gen.sv
pool_max_unit.sv
pool_top.sv
tb_pool.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the pooling testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f sources.f --top-module tb_pool -Mdir "$OBJ" -o sim_pool
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/sim_pool" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
	exit 1
fi

if ! grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG"; then
	echo "simulation log holds no result"
	exit 1
fi

exit 0
